// ==== hdl/cpu_pkg.sv ====
`default_nettype none

package cpu_pkg;

	// major opcodes, instruction bits 30:25
	localparam logic [5:0] op_base = 6'b100000;
	localparam logic [5:0] op_addi = 6'b101000;
	localparam logic [5:0] op_ori = 6'b101100;
	localparam logic [5:0] op_xori = 6'b101011;
	localparam logic [5:0] op_movi = 6'b100010;
	localparam logic [5:0] op_lwi = 6'b000010;
	localparam logic [5:0] op_swi = 6'b001010;
	localparam logic [5:0] op_ls = 6'b011100;

	// base sub-ops, bits 4:0
	localparam logic [4:0] sub_add = 5'b00000;
	localparam logic [4:0] sub_sub = 5'b00001;
	localparam logic [4:0] sub_and = 5'b00010;
	localparam logic [4:0] sub_xor = 5'b00011;
	localparam logic [4:0] sub_or = 5'b00100;
	localparam logic [4:0] sub_slli = 5'b01000;
	localparam logic [4:0] sub_srli = 5'b01001;
	localparam logic [4:0] sub_rotri = 5'b01011;

	// indexed load/store sub-ops, bits 7:0
	localparam logic [7:0] sub_lw = 8'b00000010;
	localparam logic [7:0] sub_sw = 8'b00001010;

	localparam logic [2:0] alu_add = 3'd0;
	localparam logic [2:0] alu_sub = 3'd1;
	localparam logic [2:0] alu_and = 3'd2;
	localparam logic [2:0] alu_or = 3'd3;
	localparam logic [2:0] alu_xor = 3'd4;
	localparam logic [2:0] alu_srl = 3'd5;
	localparam logic [2:0] alu_sll = 3'd6;
	localparam logic [2:0] alu_rotr = 3'd7;

	localparam logic [1:0] opb_reg = 2'd0;
	localparam logic [1:0] opb_imm_sign15 = 2'd1;
	localparam logic [1:0] opb_imm_zero15 = 2'd2;
	localparam logic [1:0] opb_shamt = 2'd3;

	localparam logic [1:0] res_alu = 2'd0;
	localparam logic [1:0] res_imm20 = 2'd1;
	localparam logic [1:0] res_mem = 2'd2;

	localparam logic addr_imm = 1'b0;
	localparam logic addr_index = 1'b1;

	localparam int reg_count = 32;
	localparam int reg_addr_width = 5;
	localparam int data_width = 32;
	localparam logic [31:0] pc_step = 32'd4;

	// imm20 is {ra, imm15} of the immediate form
	typedef union packed {
		struct packed {
			logic reserved;
			logic [5:0] opcode;
			logic [4:0] rt;
			logic [4:0] ra;
			logic [4:0] rb;
			logic [1:0] sv;
			logic [7:0] sub_op;
		} base;
		struct packed {
			logic reserved;
			logic [5:0] opcode;
			logic [4:0] rt;
			logic [4:0] ra;
			logic [14:0] imm15;
		} imm;
	} instr_word;

endpackage

`default_nettype wire

// ==== hdl/phase_sequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

module phase_sequencer (
	input wire clock,
	input wire reset,
	output logic fetch_phase,
	output logic decode_phase,
	output logic execute_phase,
	output logic memory_phase,
	output logic writeback_phase
);

	// one-hot, bit 0 is fetch
	logic [4:0] state;

	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			state <= 5'b00001;
		end else begin
			state <= {state[3:0], state[4]};
		end
	end

	assign fetch_phase = state[0];
	assign decode_phase = state[1];
	assign execute_phase = state[2];
	assign memory_phase = state[3];
	assign writeback_phase = state[4];

	state_onehot: assert property (
		@(posedge clock) disable iff (reset)
		$onehot(state)
	);

endmodule

`default_nettype wire

// ==== hdl/instr_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module instr_decoder (
	input wire cpu_pkg::instr_word instruction,
	output logic [2:0] alu_op,
	output logic [1:0] operand_b_select,
	output logic [1:0] result_select,
	output logic address_mode,
	output logic mem_read,
	output logic mem_write,
	output logic reg_write,
	output logic illegal
);

	always_comb begin
		alu_op = cpu_pkg::alu_add;
		operand_b_select = cpu_pkg::opb_reg;
		result_select = cpu_pkg::res_alu;
		address_mode = cpu_pkg::addr_imm;
		mem_read = 1'b0;
		mem_write = 1'b0;
		reg_write = 1'b0;
		illegal = 1'b0;
		case (instruction.base.opcode)
			cpu_pkg::op_base: begin
				reg_write = 1'b1;
				case (instruction.base.sub_op[4:0])
					cpu_pkg::sub_add: alu_op = cpu_pkg::alu_add;
					cpu_pkg::sub_sub: alu_op = cpu_pkg::alu_sub;
					cpu_pkg::sub_and: alu_op = cpu_pkg::alu_and;
					cpu_pkg::sub_or: alu_op = cpu_pkg::alu_or;
					cpu_pkg::sub_xor: alu_op = cpu_pkg::alu_xor;
					// shift amount sits in the rb field
					cpu_pkg::sub_srli: begin
						alu_op = cpu_pkg::alu_srl;
						operand_b_select = cpu_pkg::opb_shamt;
					end
					cpu_pkg::sub_slli: begin
						alu_op = cpu_pkg::alu_sll;
						operand_b_select = cpu_pkg::opb_shamt;
					end
					cpu_pkg::sub_rotri: begin
						alu_op = cpu_pkg::alu_rotr;
						operand_b_select = cpu_pkg::opb_shamt;
					end
					default: begin
						reg_write = 1'b0;
						illegal = 1'b1;
					end
				endcase
			end
			cpu_pkg::op_addi: begin
				operand_b_select = cpu_pkg::opb_imm_sign15;
				reg_write = 1'b1;
			end
			cpu_pkg::op_ori: begin
				alu_op = cpu_pkg::alu_or;
				operand_b_select = cpu_pkg::opb_imm_zero15;
				reg_write = 1'b1;
			end
			cpu_pkg::op_xori: begin
				alu_op = cpu_pkg::alu_xor;
				operand_b_select = cpu_pkg::opb_imm_zero15;
				reg_write = 1'b1;
			end
			cpu_pkg::op_movi: begin
				result_select = cpu_pkg::res_imm20;
				reg_write = 1'b1;
			end
			cpu_pkg::op_lwi: begin
				result_select = cpu_pkg::res_mem;
				mem_read = 1'b1;
				reg_write = 1'b1;
			end
			cpu_pkg::op_swi: mem_write = 1'b1;
			cpu_pkg::op_ls: begin
				address_mode = cpu_pkg::addr_index;
				case (instruction.base.sub_op)
					cpu_pkg::sub_lw: begin
						result_select = cpu_pkg::res_mem;
						mem_read = 1'b1;
						reg_write = 1'b1;
					end
					cpu_pkg::sub_sw: mem_write = 1'b1;
					default: illegal = 1'b1;
				endcase
			end
			default: illegal = 1'b1;
		endcase
	end

	// no clock here, so checked whenever the decode settles
	always_comb begin
		read_write_exclusive: assert (!(mem_read && mem_write));
	end

endmodule

`default_nettype wire

// ==== hdl/register_file.sv ====
`timescale 1ns/1ps
`default_nettype none

module register_file (
	input wire clock,
	input wire reset,
	input wire [cpu_pkg::reg_addr_width-1:0] read_address_a,
	input wire [cpu_pkg::reg_addr_width-1:0] read_address_b,
	input wire [cpu_pkg::reg_addr_width-1:0] write_address,
	input wire write_enable,
	input wire [cpu_pkg::data_width-1:0] write_data,
	output logic [cpu_pkg::data_width-1:0] read_data_a,
	output logic [cpu_pkg::data_width-1:0] read_data_b
);

	logic [cpu_pkg::data_width-1:0] registers [cpu_pkg::reg_count];

	// r0 is an ordinary register in this ISA
	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			for (int i = 0; i < cpu_pkg::reg_count; i++) begin
				registers[i] <= '0;
			end
		end else if (write_enable) begin
			registers[write_address] <= write_data;
		end
	end

	assign read_data_a = registers[read_address_a];
	assign read_data_b = registers[read_address_b];

endmodule

`default_nettype wire

// ==== hdl/datapath.sv ====
`timescale 1ns/1ps
`default_nettype none

module datapath (
	input wire clock,
	input wire reset,
	input wire fetch_phase,
	input wire decode_phase,
	input wire execute_phase,
	input wire memory_phase,
	input wire writeback_phase,
	input wire [2:0] alu_op,
	input wire [1:0] operand_b_select,
	input wire [1:0] result_select,
	input wire address_mode,
	input wire mem_read,
	input wire mem_write,
	input wire reg_write,
	input wire [cpu_pkg::data_width-1:0] ir,
	output cpu_pkg::instr_word instruction,
	output logic [cpu_pkg::data_width-1:0] pc,
	output logic im_enable,
	output logic dm_enable,
	output logic dm_read,
	output logic dm_write,
	output logic [cpu_pkg::data_width-1:0] dm_address,
	output logic [cpu_pkg::data_width-1:0] dm_wdata,
	input wire [cpu_pkg::data_width-1:0] dm_rdata
);

	logic [cpu_pkg::data_width-1:0] read_data_a, read_data_b, operand_a, operand_b;
	logic [cpu_pkg::data_width-1:0] alu_b, alu_value, alu_result, address_value;
	logic [cpu_pkg::data_width-1:0] load_data, writeback_data;
	logic [cpu_pkg::reg_addr_width-1:0] read_address_b;
	logic [14:0] imm15;
	logic [4:0] shamt;

	assign imm15 = instruction.imm.imm15;
	// port b reads rb in decode and the store data (rt) in execute
	assign read_address_b = decode_phase ? instruction.base.rb : instruction.base.rt;

	register_file rf0 (
		.clock(clock),
		.reset(reset),
		.read_address_a(instruction.base.ra),
		.read_address_b(read_address_b),
		.write_address(instruction.base.rt),
		.write_enable(reg_write & writeback_phase),
		.write_data(writeback_data),
		.read_data_a(read_data_a),
		.read_data_b(read_data_b)
	);

	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			pc <= '0;
			instruction <= '0;
		end else if (fetch_phase) begin
			pc <= pc + cpu_pkg::pc_step;
			instruction <= ir;
		end
	end

	always_ff @(posedge clock) begin
		if (decode_phase) begin
			operand_a <= read_data_a;
			operand_b <= read_data_b;
		end
		if (execute_phase) begin
			alu_result <= alu_value;
			dm_address <= address_value;
			dm_wdata <= read_data_b;
		end
		if (memory_phase && mem_read) begin
			load_data <= dm_rdata;
		end
	end

	always_comb begin
		case (operand_b_select)
			cpu_pkg::opb_reg: alu_b = operand_b;
			cpu_pkg::opb_imm_sign15: alu_b = {{17{imm15[14]}}, imm15};
			cpu_pkg::opb_imm_zero15: alu_b = {17'b0, imm15};
			cpu_pkg::opb_shamt: alu_b = {27'b0, instruction.base.rb};
		endcase
	end

	assign shamt = alu_b[4:0];

	always_comb begin
		case (alu_op)
			cpu_pkg::alu_add: alu_value = operand_a + alu_b;
			cpu_pkg::alu_sub: alu_value = operand_a - alu_b;
			cpu_pkg::alu_and: alu_value = operand_a & alu_b;
			cpu_pkg::alu_or: alu_value = operand_a | alu_b;
			cpu_pkg::alu_xor: alu_value = operand_a ^ alu_b;
			cpu_pkg::alu_srl: alu_value = operand_a >> shamt;
			cpu_pkg::alu_sll: alu_value = operand_a << shamt;
			// a shift by 32 gives zero, so rotate by 0 keeps the value
			cpu_pkg::alu_rotr: alu_value = (operand_a >> shamt)
				| (operand_a << (6'd32 - {1'b0, shamt}));
		endcase
	end

	assign address_value = (address_mode == cpu_pkg::addr_index)
		? operand_a + (operand_b << instruction.base.sv)
		: operand_a + {{15{imm15[14]}}, imm15, 2'b00};

	always_comb begin
		case (result_select)
			cpu_pkg::res_imm20: writeback_data = {{12{instruction.imm.ra[4]}},
				instruction.imm.ra, imm15};
			cpu_pkg::res_mem: writeback_data = load_data;
			default: writeback_data = alu_result;
		endcase
	end

	// sequencer sits in fetch during reset, keep the memory idle
	assign im_enable = fetch_phase & ~reset;
	assign dm_read = memory_phase & mem_read;
	assign dm_write = memory_phase & mem_write;
	assign dm_enable = dm_read | dm_write;

	dm_after_fetch: assert property (
		@(posedge clock) disable iff (reset)
		dm_enable |-> memory_phase && $past(im_enable, 3)
	);

endmodule

`default_nettype wire

// ==== hdl/cpu_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpu_core (
	input wire clock,
	input wire reset,
	output logic [cpu_pkg::data_width-1:0] pc,
	output logic im_enable,
	input wire [cpu_pkg::data_width-1:0] ir,
	output logic dm_enable,
	output logic dm_read,
	output logic dm_write,
	output logic [cpu_pkg::data_width-1:0] dm_address,
	output logic [cpu_pkg::data_width-1:0] dm_wdata,
	input wire [cpu_pkg::data_width-1:0] dm_rdata
);

	logic fetch_phase, decode_phase, execute_phase, memory_phase, writeback_phase;
	cpu_pkg::instr_word instruction;
	logic [2:0] alu_op;
	logic [1:0] operand_b_select;
	logic [1:0] result_select;
	logic address_mode, mem_read, mem_write, reg_write;

	phase_sequencer sequencer0 (
		.clock(clock),
		.reset(reset),
		.fetch_phase(fetch_phase),
		.decode_phase(decode_phase),
		.execute_phase(execute_phase),
		.memory_phase(memory_phase),
		.writeback_phase(writeback_phase)
	);

	// illegal already forces every enable low
	instr_decoder decoder0 (
		.instruction(instruction),
		.alu_op(alu_op),
		.operand_b_select(operand_b_select),
		.result_select(result_select),
		.address_mode(address_mode),
		.mem_read(mem_read),
		.mem_write(mem_write),
		.reg_write(reg_write),
		.illegal()
	);

	datapath datapath0 (
		.clock(clock),
		.reset(reset),
		.fetch_phase(fetch_phase),
		.decode_phase(decode_phase),
		.execute_phase(execute_phase),
		.memory_phase(memory_phase),
		.writeback_phase(writeback_phase),
		.alu_op(alu_op),
		.operand_b_select(operand_b_select),
		.result_select(result_select),
		.address_mode(address_mode),
		.mem_read(mem_read),
		.mem_write(mem_write),
		.reg_write(reg_write),
		.ir(ir),
		.instruction(instruction),
		.pc(pc),
		.im_enable(im_enable),
		.dm_enable(dm_enable),
		.dm_read(dm_read),
		.dm_write(dm_write),
		.dm_address(dm_address),
		.dm_wdata(dm_wdata),
		.dm_rdata(dm_rdata)
	);

endmodule

`default_nettype wire

// ==== verification/cpu_core_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpu_core_tb;

	localparam int clock_period = 10;
	localparam int test_count = 6;
	// SRLI r0,r0,0 fills the instruction memory past the program
	localparam logic [31:0] nop_word = 32'h40000009;

	logic clock = 1'b0;
	logic reset = 1'b1;
	logic [31:0] ir = '0;
	logic [31:0] dm_rdata = '0;
	logic [31:0] pc, dm_address, dm_wdata;
	logic im_enable, dm_enable, dm_read, dm_write;

	logic [31:0] imem [256];
	logic [31:0] dmem [256];
	logic [31:0] expect_address [$];
	logic [31:0] expect_data [$];
	int expect_test [$];
	int errors [0:test_count] = '{default: 0};
	int prog_count = 0;
	int store_index = 0;
	int since_fetch = 0;
	logic [31:0] last_fetch_pc = '0;
	logic loaded = 1'b0;
	logic started = 1'b0;
	logic finished = 1'b0;

	cpu_core dut0 (
		.clock(clock),
		.reset(reset),
		.pc(pc),
		.im_enable(im_enable),
		.ir(ir),
		.dm_enable(dm_enable),
		.dm_read(dm_read),
		.dm_write(dm_write),
		.dm_address(dm_address),
		.dm_wdata(dm_wdata),
		.dm_rdata(dm_rdata)
	);

	always #(clock_period / 2) clock = ~clock;

	function automatic string test_name(int test);
		case (test)
			1: return "reset and first fetch";
			2: return "phase timing";
			3: return "alu operations";
			4: return "loads and stores";
			5: return "illegal encodings";
			default: return "completeness";
		endcase
	endfunction

	task automatic report_mismatch(int test, string name, logic [31:0] expected,
			logic [31:0] actual);
		$display("CHECK FAILED at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
		errors[test]++;
	endtask

	task automatic report_test(int test);
		if (errors[test] == 0) begin
			$display("test %0d %s passed", test, test_name(test));
		end else begin
			$display("test %0d %s failed with %0d errors", test, test_name(test), errors[test]);
		end
	endtask

	// records are I word, D address data, W address data test
	task automatic load_stimulus();
		int fd;
		int code;
		int test;
		logic [7:0] tag;
		logic [31:0] first;
		logic [31:0] second;
		logic [8*160-1:0] rest;
		fd = $fopen("verification/cpu_stim.txt", "r");
		if (fd == 0) begin
			$display("Stimulus file verification/cpu_stim.txt could not be opened");
			errors[0]++;
			return;
		end
		while ($fscanf(fd, " %s", tag) == 1) begin
			case (tag)
				"#": code = $fgets(rest, fd);
				"I": begin
					code = $fscanf(fd, "%h", first);
					imem[prog_count[7:0]] = first;
					prog_count++;
				end
				"D": begin
					code = $fscanf(fd, "%h %h", first, second);
					dmem[first[9:2]] = second;
				end
				"W": begin
					code = $fscanf(fd, "%h %h %d", first, second, test);
					expect_address.push_back(first);
					expect_data.push_back(second);
					expect_test.push_back(test);
				end
				default: begin
					$display("Stimulus file holds a record of unknown kind");
					errors[0]++;
				end
			endcase
		end
		$fclose(fd);
	endtask

	task automatic check_store();
		int test;
		if (store_index >= expect_address.size()) begin
			$display("Unexpected store of %h to address %h at %0t ns", dm_wdata, dm_address, $time);
			errors[6]++;
		end else begin
			test = expect_test[store_index];
			if (dm_address !== expect_address[store_index]) begin
				report_mismatch(test, "dm_address", expect_address[store_index], dm_address);
			end
			if (dm_wdata !== expect_data[store_index]) begin
				report_mismatch(test, "dm_wdata", expect_data[store_index], dm_wdata);
			end
			store_index++;
		end
		dmem[dm_address[9:2]] = dm_wdata;
	endtask

	// memories answer and outputs are sampled on the falling edge
	always @(negedge clock) begin
		if (started && !finished) begin
			since_fetch++;
			if (im_enable) begin
				if (since_fetch != 5) begin
					$display("Fetch came %0d cycles after the previous one at %0t ns",
						since_fetch, $time);
					errors[2]++;
				end
				if (pc !== last_fetch_pc + 32'd4) begin
					report_mismatch(2, "pc", last_fetch_pc + 32'd4, pc);
				end
				last_fetch_pc = last_fetch_pc + 32'd4;
				since_fetch = 0;
				if (last_fetch_pc == prog_count * 4) begin
					finished = 1'b1;
				end
			end else if (since_fetch > 5) begin
				$display("No fetch within five cycles at %0t ns", $time);
				errors[2]++;
				since_fetch = 0;
			end
			if (dm_enable && since_fetch != 3) begin
				$display("Data memory access %0d cycles after fetch at %0t ns", since_fetch, $time);
				errors[2]++;
			end
			if (dm_enable !== (dm_read | dm_write) || (dm_read && dm_write)) begin
				$display("Data memory strobes disagree at %0t ns: enable %b read %b write %b",
					$time, dm_enable, dm_read, dm_write);
				errors[4]++;
			end
			if (dm_enable && dm_write) begin
				check_store();
			end
		end
		ir = imem[pc[9:2]];
		dm_rdata = dm_read ? dmem[dm_address[9:2]] : '0;
	end

	initial begin
		int passed;
		int total;
		passed = 0;
		total = 0;
		void'($urandom(29238));
		for (int i = 0; i < 256; i++) begin
			imem[i[7:0]] = nop_word;
			dmem[i[7:0]] = $urandom();
		end
		load_stimulus();
		loaded = 1'b1;
		repeat (4) begin
			@(negedge clock);
			if (im_enable || dm_enable || dm_read || dm_write) begin
				$display("Memory strobe high during reset at %0t ns", $time);
				errors[1]++;
			end
		end
		reset = 1'b0;
		#1;
		if (im_enable !== 1'b1) begin
			report_mismatch(1, "im_enable", 32'd1, {31'b0, im_enable});
		end
		if (pc !== 32'd0) begin
			report_mismatch(1, "pc", 32'd0, pc);
		end
		started = 1'b1;
		report_test(1);
		wait (finished);
		if (store_index != expect_address.size()) begin
			$display("Only %0d of %0d expected stores happened", store_index,
				expect_address.size());
			errors[6]++;
		end
		for (int t = 2; t <= test_count; t++) begin
			report_test(t);
		end
		for (int t = 0; t <= test_count; t++) begin
			total += errors[t];
			if (t > 0 && errors[t] == 0) begin
				passed++;
			end
		end
		$display("%0d tests passed, %0d tests failed, %0d errors", passed,
			test_count - passed, total);
		if (total == 0) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

	// five cycles per program word plus some slack
	initial begin
		wait (loaded);
		#(prog_count * 5 * clock_period + 200);
		$display("Timeout before the end of the program at %0t ns", $time);
		$display("Simulation failed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== verification/cpu_stim.txt ====
# I word | D address data | W address data test
# all values hex except test, the number of the behavior a store belongs to
D 00000200 CAFEF00D
I 441FFFFB
I 44212345
I 40308800
I 14300040
I 40410401
I 14400041
I 40508802
I 14500042
I 40608804
I 14600043
I 40708803
I 14700044
I 50817CBB
I 14800045
I 58914000
I 14900046
I 56A0FFFF
I 14A00047
I 40B09009
I 14B00048
I 40C13008
I 14C00049
I 40D1200B
I 14D0004A
# loads and indexed stores, r15 base and r16 index
I 04E00080
I 14E0004B
I 44F00300
I 45000004
I 38E7C00A
I 3837C10A
I 3847C20A
I 3857C30A
I 3917C302
I 1510004C
# unknown opcode, ls sub-op and base sub-op, all aimed at r1
I 7E100000
I 3817C00B
I 4010001F
I 1410004D
W 00000100 00012340 3
W 00000104 0001234A 3
W 00000108 00012341 3
W 0000010C FFFFFFFF 3
W 00000110 FFFEDCBE 3
W 00000114 00012000 3
W 00000118 00016345 3
W 0000011C FFFF8004 3
W 00000120 0FFFFFFF 3
W 00000124 12345000 3
W 00000128 45000123 3
W 0000012C CAFEF00D 4
W 00000304 CAFEF00D 4
W 00000308 00012340 4
W 00000310 0001234A 4
W 00000320 00012341 4
W 00000130 00012341 4
W 00000134 FFFFFFFB 5

// ==== compile.f ====
hdl/cpu_pkg.sv
hdl/phase_sequencer.sv
hdl/instr_decoder.sv
hdl/register_file.sv
hdl/datapath.sv
hdl/cpu_core.sv
verification/cpu_core_tb.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS = --binary --timing --assert -j 0
TOP = cpu_core_tb
FILELIST = compile.f
BUILD_DIR = obj_dir
PASS_MESSAGE = Simulation passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MESSAGE)"

lint:
	$(VERILATOR) --lint-only --timing --assert --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)
